// ==== build.f ====
rtl/pod_pkg.sv
rtl/pod_link_if.sv
rtl/pod_io_router.sv
rtl/pod_compute_tile.sv
rtl/pod_resp_fifo.sv
rtl/pod_top.sv
verification/pod_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the pod testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module pod_tb -Mdir obj_dir &&
  out=$(./obj_dir/Vpod_tb) ;
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "RESULT: PASS" ||
  { echo "RESULT: FAIL"; exit 1; }

// ==== verification/pod_tb.sv ====
// pod testbench
// table of store and load steps with expected responses,
// reset hand-off checks and back-pressure bursts
`timescale 1ns/1ps
`default_nettype none

module pod_tb
  import pod_pkg::*;
();

  typedef struct packed {
    pod_op_e                 op;
    logic [X_CORD_WIDTH-1:0] x;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
    logic [TAG_WIDTH-1:0]    tag;
    logic [DATA_WIDTH-1:0]   exp_data;
    logic                    stall;
  } step_s;

  localparam int NUM_STEPS      = 17;
  localparam int TIMEOUT_CYCLES = NUM_STEPS * 40 + 200;

  // op, x, addr, data, tag, expected data, stall
  step_s steps [NUM_STEPS] = '{
    '{OP_STORE, 2'd0, 4'd3,  32'h1111_0003, 4'd1,  32'h1111_0003, 1'b0},
    '{OP_STORE, 2'd1, 4'd3,  32'h2222_0003, 4'd2,  32'h2222_0003, 1'b0},
    '{OP_STORE, 2'd2, 4'd5,  32'h3333_0005, 4'd3,  32'h3333_0005, 1'b0},
    '{OP_STORE, 2'd3, 4'd15, 32'h4444_000f, 4'd4,  32'h4444_000f, 1'b0},
    '{OP_LOAD,  2'd0, 4'd3,  32'h0,         4'd5,  32'h1111_0003, 1'b0},
    '{OP_LOAD,  2'd1, 4'd3,  32'h0,         4'd6,  32'h2222_0003, 1'b0},
    '{OP_LOAD,  2'd2, 4'd5,  32'h0,         4'd7,  32'h3333_0005, 1'b0},
    '{OP_LOAD,  2'd3, 4'd15, 32'h0,         4'd8,  32'h4444_000f, 1'b0},
    // column 1 only, other columns still read zero
    '{OP_STORE, 2'd1, 4'd9,  32'hdead_beef, 4'd9,  32'hdead_beef, 1'b0},
    '{OP_LOAD,  2'd0, 4'd9,  32'h0,         4'd10, 32'h0,         1'b0},
    '{OP_LOAD,  2'd2, 4'd9,  32'h0,         4'd11, 32'h0,         1'b0},
    '{OP_LOAD,  2'd3, 4'd9,  32'h0,         4'd12, 32'h0,         1'b0},
    '{OP_STORE, 2'd1, 4'd9,  32'h0bad_cafe, 4'd13, 32'h0bad_cafe, 1'b0},
    '{OP_LOAD,  2'd1, 4'd9,  32'h0,         4'd14, 32'h0bad_cafe, 1'b0},
    // burst to one column under back-pressure
    '{OP_STORE, 2'd2, 4'd7,  32'h5555_0001, 4'd15, 32'h5555_0001, 1'b1},
    '{OP_STORE, 2'd2, 4'd7,  32'h5555_0002, 4'd0,  32'h5555_0002, 1'b1},
    '{OP_LOAD,  2'd2, 4'd7,  32'h0,         4'd1,  32'h5555_0002, 1'b1}
  };

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  pod_op_e                 req_op_i;
  logic [X_CORD_WIDTH-1:0] req_x_i;
  logic [ADDR_WIDTH-1:0]   req_addr_i;
  logic [DATA_WIDTH-1:0]   req_data_i;
  logic [TAG_WIDTH-1:0]    req_tag_i;
  logic                    rsp_valid_o;
  logic                    rsp_ready_i;
  pod_op_e                 rsp_op_o;
  logic [X_CORD_WIDTH-1:0] rsp_x_o;
  logic [DATA_WIDTH-1:0]   rsp_data_o;
  logic [TAG_WIDTH-1:0]    rsp_tag_o;
  logic                    hor_reset_o;
  logic [NUM_TILES_X-1:0]  ver_reset_o;

  int error_count = 0;
  int cycle_count = 0;

  always #20 clk_i = ~clk_i;

  pod_top dut_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_x_i     (req_x_i),
    .req_addr_i  (req_addr_i),
    .req_data_i  (req_data_i),
    .req_tag_i   (req_tag_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_op_o    (rsp_op_o),
    .rsp_x_o     (rsp_x_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_tag_o   (rsp_tag_o),
    .hor_reset_o (hor_reset_o),
    .ver_reset_o (ver_reset_o)
  );

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: no response after %0d cycles", cycle_count);
      $display("Some tests failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input int i);
    req_valid_i = 1'b1;
    req_op_i    = steps[i].op;
    req_x_i     = steps[i].x;
    req_addr_i  = steps[i].addr;
    req_data_i  = steps[i].data;
    req_tag_i   = steps[i].tag;
    #1;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
  endtask

  task automatic wait_rsp(input int i);
    while (!rsp_valid_o) @(negedge clk_i);
    check_value("rsp_op_o", 32'(rsp_op_o), 32'(steps[i].op));
    check_value("rsp_x_o", 32'(rsp_x_o), 32'(steps[i].x));
    check_value("rsp_data_o", rsp_data_o, steps[i].exp_data);
    check_value("rsp_tag_o", 32'(rsp_tag_o), 32'(steps[i].tag));
    @(negedge clk_i);
  endtask

  initial begin
    int i;
    int first;
    int stall_cycles;

    void'($urandom(32'h6aeb_de1a));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = OP_STORE;
    req_x_i     = '0;
    req_addr_i  = '0;
    req_data_i  = '0;
    req_tag_i   = '0;
    rsp_ready_i = 1'b1;

    repeat (2) @(negedge clk_i);
    repeat (8) begin
      @(negedge clk_i);
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
      check_value("req_ready_o", 32'(req_ready_o), 32'd0);
    end
    check_value("ver_reset_o", 32'(ver_reset_o), 32'hf);
    check_value("hor_reset_o", 32'(hor_reset_o), 32'd1);
    reset_i = 1'b0;

    // reset ripples east one column per cycle
    for (int k = 1; k <= NUM_TILES_X; k++) begin
      @(negedge clk_i);
      check_value("ver_reset_o", 32'(ver_reset_o), 32'(4'(4'hf << k)));
      check_value("hor_reset_o", 32'(hor_reset_o), (k == NUM_TILES_X) ? 32'd0 : 32'd1);
    end

    i = 0;
    while (i < NUM_STEPS) begin
      if (steps[i].stall) begin
        first       = i;
        rsp_ready_i = 1'b0;
        while (i < NUM_STEPS && steps[i].stall) begin
          send_req(i);
          i++;
        end
        req_valid_i  = 1'b0;
        // hold the queue head until the burst has backed up behind it
        while (!rsp_valid_o) @(negedge clk_i);
        stall_cycles = 3 + int'($urandom % 8);
        repeat (stall_cycles) @(negedge clk_i);
        rsp_ready_i = 1'b1;
        for (int j = first; j < i; j++) begin
          wait_rsp(j);
        end
      end else begin
        send_req(i);
        req_valid_i = 1'b0;
        wait_rsp(i);
        i++;
      end
      // nothing extra left in the queue
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    end

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/pod_top.sv ====
// pod top
// one row of four compute tiles fed by an I/O router chain,
// responses leave through a small queue to the host
`timescale 1ns/1ps
`default_nettype none

module pod_top
  import pod_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  pod_op_e                 req_op_i,
  input  logic [X_CORD_WIDTH-1:0] req_x_i,
  input  logic [ADDR_WIDTH-1:0]   req_addr_i,
  input  logic [DATA_WIDTH-1:0]   req_data_i,
  input  logic [TAG_WIDTH-1:0]    req_tag_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output pod_op_e                 rsp_op_o,
  output logic [X_CORD_WIDTH-1:0] rsp_x_o,
  output logic [DATA_WIDTH-1:0]   rsp_data_o,
  output logic [TAG_WIDTH-1:0]    rsp_tag_o,
  output logic                    hor_reset_o,
  output logic [NUM_TILES_X-1:0]  ver_reset_o
);

  // chain_link[0] faces the host, the last one is the open east end
  pod_link_if chain_link [NUM_TILES_X+1] ();
  pod_link_if tile_link [NUM_TILES_X] ();

  logic [NUM_TILES_X:0] reset_chain;
  pod_rsp_s             host_rsp;

  assign reset_chain[0] = reset_i;

  assign chain_link[0].req_valid = req_valid_i;
  assign chain_link[0].req       = '{op: req_op_i, x: req_x_i, addr: req_addr_i,
                                     data: req_data_i, tag: req_tag_i};
  assign req_ready_o             = chain_link[0].req_ready;

  // east end tie-off
  assign chain_link[NUM_TILES_X].req_ready = 1'b0;
  assign chain_link[NUM_TILES_X].rsp_valid = 1'b0;
  assign chain_link[NUM_TILES_X].rsp       = '0;

  for (genvar c = 0; c < NUM_TILES_X; c++) begin : col
    pod_io_router #(.my_x(c)) io_rtr (
      .clk_i   (clk_i),
      .reset_i (reset_chain[c]),
      .reset_o (reset_chain[c+1]),
      .west    (chain_link[c]),
      .east    (chain_link[c+1]),
      .tile    (tile_link[c])
    );

    pod_compute_tile #(.my_x(c)) tile (
      .clk_i   (clk_i),
      .reset_i (reset_chain[c+1]),
      .link    (tile_link[c])
    );
  end

  assign ver_reset_o = reset_chain[NUM_TILES_X:1];
  assign hor_reset_o = reset_chain[NUM_TILES_X];

  pod_resp_fifo rsp_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .up          (chain_link[0]),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (host_rsp)
  );

  assign rsp_op_o   = host_rsp.op;
  assign rsp_x_o    = host_rsp.x;
  assign rsp_data_o = host_rsp.data;
  assign rsp_tag_o  = host_rsp.tag;

endmodule

`default_nettype wire

// ==== rtl/pod_resp_fifo.sv ====
// pod response queue
// circular buffer between the router chain and the host response port
`timescale 1ns/1ps
`default_nettype none

module pod_resp_fifo
  import pod_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  pod_link_if.west_mp up,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output pod_rsp_s    rsp_o
);

  pod_rsp_s mem_r [RSP_FIFO_DEPTH];

  logic [RSP_PTR_WIDTH-1:0] wr_ptr_r;
  logic [RSP_PTR_WIDTH-1:0] rd_ptr_r;
  logic [RSP_CNT_WIDTH-1:0] count_r;

  logic full;
  logic push;
  logic pop;

  assign full         = (count_r == RSP_CNT_WIDTH'(RSP_FIFO_DEPTH));
  assign up.rsp_ready = !full;
  assign push         = up.rsp_valid && up.rsp_ready;
  assign rsp_valid_o  = (count_r != '0);
  assign pop          = rsp_valid_o && rsp_ready_i;
  assign rsp_o        = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (pop) rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_r[wr_ptr_r] <= up.rsp;
  end

  // count stays in range and matches the pointers
  a_no_overrun: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_r <= RSP_CNT_WIDTH'(RSP_FIFO_DEPTH)) &&
    (RSP_PTR_WIDTH'(wr_ptr_r - rd_ptr_r) == count_r[RSP_PTR_WIDTH-1:0]));

endmodule

`default_nettype wire

// ==== rtl/pod_compute_tile.sv ====
// pod compute tile
// 16-word local data memory serving store and load requests,
// one response register toward the router
`timescale 1ns/1ps
`default_nettype none

module pod_compute_tile
  import pod_pkg::*;
#(
  parameter int my_x = 0
) (
  input  logic        clk_i,
  input  logic        reset_i,
  pod_link_if.east_mp link
);

  logic [DATA_WIDTH-1:0] mem_r [DMEM_WORDS];

  logic     rsp_v_r;
  pod_rsp_s rsp_r;
  logic     req_take;

  assign link.req_ready = !rsp_v_r || link.rsp_ready;
  assign req_take       = link.req_valid && link.req_ready;

  // memory, cleared on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else if (req_take && (link.req.op == OP_STORE)) begin
      mem_r[link.req.addr] <= link.req.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_r <= 1'b0;
    end else if (req_take) begin
      rsp_v_r <= 1'b1;
    end else if (link.rsp_ready) begin
      rsp_v_r <= 1'b0;
    end
  end

  // store echoes the written word
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      rsp_r.op  <= link.req.op;
      rsp_r.x   <= X_CORD_WIDTH'(my_x);
      rsp_r.tag <= link.req.tag;
      if (link.req.op == OP_STORE) begin
        rsp_r.data <= link.req.data;
      end else begin
        rsp_r.data <= mem_r[link.req.addr];
      end
    end
  end

  assign link.rsp_valid = rsp_v_r;
  assign link.rsp       = rsp_r;

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_v_r && !link.rsp_ready |=> rsp_v_r && $stable(rsp_r));

endmodule

`default_nettype wire

// ==== rtl/pod_io_router.sv ====
// pod I/O router
// steers requests east or down to its own tile, merges tile and
// east responses round-robin toward the west, and hops reset by a cycle
`timescale 1ns/1ps
`default_nettype none

module pod_io_router
  import pod_pkg::*;
#(
  parameter int my_x = 0
) (
  input  logic        clk_i,
  input  logic        reset_i,
  output logic        reset_o,
  pod_link_if.east_mp west,
  pod_link_if.west_mp east,
  pod_link_if.west_mp tile
);

  logic     reset_r;
  logic     accept_en_r;

  logic     tile_req_v_r;
  pod_req_s tile_req_r;
  logic     east_req_v_r;
  pod_req_s east_req_r;
  logic     west_rsp_v_r;
  pod_rsp_s west_rsp_r;
  logic     rr_east_r;

  logic     to_tile;
  logic     tile_free;
  logic     east_free;
  logic     west_free;
  logic     take_tile;
  logic     take_east;
  logic     grant_tile;
  logic     grant_east;

  // local reset, also forwarded to the next column
  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;
  end

  assign reset_o = reset_r;

  // request side
  assign to_tile        = (west.req.x == X_CORD_WIDTH'(my_x));
  assign tile_free      = !tile_req_v_r || tile.req_ready;
  assign east_free      = !east_req_v_r || east.req_ready;
  assign west.req_ready = accept_en_r && (to_tile ? tile_free : east_free);
  assign take_tile      = west.req_valid && west.req_ready && to_tile;
  assign take_east      = west.req_valid && west.req_ready && !to_tile;

  // response side, tile vs east
  assign west_free      = !west_rsp_v_r || west.rsp_ready;
  assign grant_tile     = tile.rsp_valid && (!east.rsp_valid || !rr_east_r);
  assign grant_east     = east.rsp_valid && (!tile.rsp_valid || rr_east_r);
  assign tile.rsp_ready = west_free && grant_tile;
  assign east.rsp_ready = west_free && grant_east;

  always_ff @(posedge clk_i) begin
    if (reset_r) begin
      accept_en_r  <= 1'b0;
      tile_req_v_r <= 1'b0;
      east_req_v_r <= 1'b0;
      west_rsp_v_r <= 1'b0;
      rr_east_r    <= 1'b0;
    end else begin
      accept_en_r <= 1'b1;
      if (take_tile) begin
        tile_req_v_r <= 1'b1;
      end else if (tile.req_ready) begin
        tile_req_v_r <= 1'b0;
      end
      if (take_east) begin
        east_req_v_r <= 1'b1;
      end else if (east.req_ready) begin
        east_req_v_r <= 1'b0;
      end
      if (west_free) begin
        west_rsp_v_r <= grant_tile || grant_east;
      end
      // tile won, so east goes first next time
      if (west_free && (grant_tile || grant_east)) begin
        rr_east_r <= grant_tile;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_tile) tile_req_r <= west.req;
    if (take_east) east_req_r <= west.req;
    if (west_free && (grant_tile || grant_east)) begin
      west_rsp_r <= grant_tile ? tile.rsp : east.rsp;
    end
  end

  assign tile.req_valid = tile_req_v_r;
  assign tile.req       = tile_req_r;
  assign east.req_valid = east_req_v_r;
  assign east.req       = east_req_r;
  assign west.rsp_valid = west_rsp_v_r;
  assign west.rsp       = west_rsp_r;

  // upstream must hold a stalled request
  a_req_hold: assert property (@(posedge clk_i) disable iff (reset_r)
    west.req_valid && !west.req_ready |=> west.req_valid && $stable(west.req));

endmodule

`default_nettype wire

// ==== rtl/pod_link_if.sv ====
// pod link
// ready/valid request channel toward the east and
// ready/valid response channel toward the west
`timescale 1ns/1ps
`default_nettype none

interface pod_link_if
  import pod_pkg::*;
();

  // requests, flowing east
  logic     req_valid;
  logic     req_ready;
  pod_req_s req;

  // responses, flowing west
  logic     rsp_valid;
  logic     rsp_ready;
  pod_rsp_s rsp;

  // side closer to the host
  modport west_mp (
    output req_valid, req, rsp_ready,
    input  req_ready, rsp_valid, rsp
  );

  modport east_mp (
    input  req_valid, req, rsp_ready,
    output req_ready, rsp_valid, rsp
  );

endinterface

`default_nettype wire

// ==== rtl/pod_pkg.sv ====
// pod package
// sizes, opcodes and packet formats shared by the router chain,
// the tile row and the host response queue
`default_nettype none

package pod_pkg;

  localparam int NUM_TILES_X    = 4;
  localparam int X_CORD_WIDTH   = 2;
  localparam int DMEM_WORDS     = 16;
  localparam int ADDR_WIDTH     = 4;
  localparam int DATA_WIDTH     = 32;
  localparam int TAG_WIDTH      = 4;
  localparam int RSP_FIFO_DEPTH = 4;
  localparam int RSP_PTR_WIDTH  = $clog2(RSP_FIFO_DEPTH);
  localparam int RSP_CNT_WIDTH  = $clog2(RSP_FIFO_DEPTH + 1);

  typedef enum logic {
    OP_STORE = 1'b0,
    OP_LOAD  = 1'b1
  } pod_op_e;

  // host to tile, x is the destination column
  typedef struct packed {
    pod_op_e                 op;
    logic [X_CORD_WIDTH-1:0] x;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
    logic [TAG_WIDTH-1:0]    tag;
  } pod_req_s;

  // tile to host, x is the column that answered
  typedef struct packed {
    pod_op_e                 op;
    logic [X_CORD_WIDTH-1:0] x;
    logic [DATA_WIDTH-1:0]   data;
    logic [TAG_WIDTH-1:0]    tag;
  } pod_rsp_s;

endpackage

`default_nettype wire
